//--- include/rv32_exec_consts.svh
// shared opcode, funct3/funct7 and width macros for the RV32IM execute unit, include where needed
`ifndef RV32_EXEC_CONSTS_SVH
`define RV32_EXEC_CONSTS_SVH

// datapath width, fixed by the ISA
`define XLEN 32

// major opcodes executed by the unit
`define OPC_OP      7'b0110011  // register-register
`define OPC_OP_IMM  7'b0010011  // register-immediate
`define OPC_LUI     7'b0110111  // load upper immediate

// funct3 codes of the base ops
// the same codes select MUL..REMU when funct7 is F7_MULDIV
`define F3_ADD   3'b000  // add/sub, mul
`define F3_SLL   3'b001  // sll, mulh
`define F3_SLT   3'b010  // slt, mulhsu
`define F3_SLTU  3'b011  // sltu, mulhu
`define F3_XOR   3'b100  // xor, div
`define F3_SRL   3'b101  // srl/sra, divu
`define F3_OR    3'b110  // or, rem
`define F3_AND   3'b111  // and, remu

// funct7 values
`define F7_BASE    7'h00
`define F7_ALT     7'h20  // sub, sra
`define F7_MULDIV  7'h01  // M extension

// immediate field widths
`define IMM_I_W  12
`define IMM_U_W  20

`endif

//--- hw/rv32_exec_pkg.sv
// types shared by the execute unit: ALU operation codes and the instruction word formats
package rv32_exec_pkg;

    // ALU operation codes, bit 4 marks sub/sra, bits 4:3 = 01 the M extension
    typedef enum logic [4:0] {
        ALU_ADD    = 5'b00000,
        ALU_SLL    = 5'b00001,
        ALU_SLT    = 5'b00010,
        ALU_SLTU   = 5'b00011,
        ALU_XOR    = 5'b00100,
        ALU_SRL    = 5'b00101,
        ALU_OR     = 5'b00110,
        ALU_AND    = 5'b00111,
        ALU_MUL    = 5'b01000,
        ALU_MULH   = 5'b01001,
        ALU_MULHSU = 5'b01010,
        ALU_MULHU  = 5'b01011,
        ALU_DIV    = 5'b01100,
        ALU_DIVU   = 5'b01101,
        ALU_REM    = 5'b01110,
        ALU_REMU   = 5'b01111,
        ALU_SUB    = 5'b10000,
        ALU_SRA    = 5'b10101,
        ALU_PASS_B = 5'b11000  // lui
    } alu_ctrl_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;  // imm[11:0], shamt in [4:0] for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;  // imm[31:12]
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    // one word, read by format according to its opcode
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } rv_instr_u;

endpackage

//--- hw/alu_if.sv
// decoder to ALU link: the decoder drives operation and operands, the ALU returns the result
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

interface alu_if import rv32_exec_pkg::*; ();

    alu_ctrl_e         alu_ctrl;
    logic [`XLEN-1:0]  alu_src0;
    logic [`XLEN-1:0]  alu_src1;
    logic [`XLEN-1:0]  alu_res;

    modport dec (
        output alu_ctrl,
        output alu_src0,
        output alu_src1
    );

    modport alu (
        input  alu_ctrl,
        input  alu_src0,
        input  alu_src1,
        output alu_res
    );

endinterface

//--- hw/alu.sv
// combinational RV32IM ALU, takes its operation and operands over alu_if
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module alu import rv32_exec_pkg::*; (
    alu_if.alu bus
);

    logic [`XLEN-1:0]          a;
    logic [`XLEN-1:0]          b;
    logic [4:0]                shamt;
    logic                      a_sgn;
    logic                      b_sgn;
    logic signed [`XLEN:0]     mul_a;
    logic signed [`XLEN:0]     mul_b;
    logic signed [2*`XLEN+1:0] mul_p;
    logic                      div_zero;
    logic                      div_ovf;

    assign a     = bus.alu_src0;
    assign b     = bus.alu_src1;
    assign shamt = b[4:0];  // only five bits count

    // one 33x33 signed multiplier serves all four multiplies
    assign a_sgn = (bus.alu_ctrl == ALU_MULH) || (bus.alu_ctrl == ALU_MULHSU);
    assign b_sgn = (bus.alu_ctrl == ALU_MULH);
    assign mul_a = {a_sgn & a[`XLEN-1], a};
    assign mul_b = {b_sgn & b[`XLEN-1], b};
    assign mul_p = mul_a * mul_b;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == {1'b1, {(`XLEN-1){1'b0}}}) && (b == '1);  // min / -1

    always_comb begin
        bus.alu_res = '0;
        case (bus.alu_ctrl)
            ALU_ADD:
                bus.alu_res = a + b;
            ALU_SUB:
                bus.alu_res = a - b;
            ALU_SLL:
                bus.alu_res = a << shamt;
            ALU_SLT:
                bus.alu_res = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:
                bus.alu_res = {{(`XLEN-1){1'b0}}, a < b};
            ALU_XOR:
                bus.alu_res = a ^ b;
            ALU_SRL:
                bus.alu_res = a >> shamt;
            ALU_SRA:
                bus.alu_res = $signed(a) >>> shamt;  // sign fill
            ALU_OR:
                bus.alu_res = a | b;
            ALU_AND:
                bus.alu_res = a & b;
            ALU_MUL:
                bus.alu_res = mul_p[`XLEN-1:0];
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:
                bus.alu_res = mul_p[2*`XLEN-1:`XLEN];  // upper half
            ALU_DIV: begin
                if (div_zero) begin
                    bus.alu_res = '1;
                end else if (div_ovf) begin
                    bus.alu_res = a;  // most negative value
                end else begin
                    bus.alu_res = $signed(a) / $signed(b);
                end
            end
            ALU_DIVU: begin
                if (div_zero) begin
                    bus.alu_res = '1;
                end else begin
                    bus.alu_res = a / b;
                end
            end
            ALU_REM: begin
                if (div_zero) begin
                    bus.alu_res = a;  // dividend
                end else if (div_ovf) begin
                    bus.alu_res = '0;
                end else begin
                    bus.alu_res = $signed(a) % $signed(b);
                end
            end
            ALU_REMU: begin
                if (div_zero) begin
                    bus.alu_res = a;
                end else begin
                    bus.alu_res = a % b;
                end
            end
            ALU_PASS_B:
                bus.alu_res = b;
            default:
                bus.alu_res = '0;
        endcase
    end

endmodule

//--- hw/exec_decoder.sv
// decodes the captured instruction word into ALU operation, operands and an illegal flag
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module exec_decoder import rv32_exec_pkg::*; (
    input  rv_instr_u        instr,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    alu_if.dec               bus,
    output logic             illegal
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [2:0]       funct3;
    logic [6:0]       funct7;

    // base op shared by OP and OP_IMM, sub/sra handled by the caller
    function automatic alu_ctrl_e base_op(input logic [2:0] f3);
        case (f3)
            `F3_ADD:  return ALU_ADD;
            `F3_SLL:  return ALU_SLL;
            `F3_SLT:  return ALU_SLT;
            `F3_SLTU: return ALU_SLTU;
            `F3_XOR:  return ALU_XOR;
            `F3_SRL:  return ALU_SRL;
            `F3_OR:   return ALU_OR;
            default:  return ALU_AND;
        endcase
    endfunction

    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;  // upper imm bits on OP_IMM shifts
    assign imm_i  = {{(`XLEN-`IMM_I_W){instr.i.imm[`IMM_I_W-1]}}, instr.i.imm};
    assign imm_u  = {instr.u.imm, {(`XLEN-`IMM_U_W){1'b0}}};

    always_comb begin
        bus.alu_ctrl = ALU_ADD;
        bus.alu_src0 = rs1_val;
        bus.alu_src1 = rs2_val;
        illegal      = 1'b0;
        case (instr.r.opcode)
            `OPC_OP: begin
                case (funct7)
                    `F7_BASE:   bus.alu_ctrl = base_op(funct3);
                    `F7_MULDIV: bus.alu_ctrl = alu_ctrl_e'({2'b01, funct3});  // mul..remu
                    `F7_ALT: begin
                        if (funct3 == `F3_ADD) begin
                            bus.alu_ctrl = ALU_SUB;
                        end else if (funct3 == `F3_SRL) begin
                            bus.alu_ctrl = ALU_SRA;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default:    illegal = 1'b1;
                endcase
            end
            `OPC_OP_IMM: begin
                bus.alu_src1 = imm_i;
                bus.alu_ctrl = base_op(funct3);
                if (funct3 == `F3_SLL && funct7 != `F7_BASE) begin
                    illegal = 1'b1;
                end else if (funct3 == `F3_SRL) begin
                    if (funct7 == `F7_ALT) begin
                        bus.alu_ctrl = ALU_SRA;  // bit 30 set
                    end else if (funct7 != `F7_BASE) begin
                        illegal = 1'b1;
                    end
                end
            end
            `OPC_LUI: begin
                bus.alu_ctrl = ALU_PASS_B;
                bus.alu_src1 = imm_u;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin  // add on zeros, result reads zero
            bus.alu_ctrl = ALU_ADD;
            bus.alu_src0 = '0;
            bus.alu_src1 = '0;
        end
    end

endmodule

//--- hw/exec_handshake.sv
// four-phase req/ack responder: captures a request, registers the ALU result, sequences ack
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module exec_handshake (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    input  logic [`XLEN-1:0] alu_res,
    input  logic             dec_illegal,
    output logic             ack,
    output logic [`XLEN-1:0] result,
    output logic             illegal,
    output logic [`XLEN-1:0] instr_q,
    output logic [`XLEN-1:0] rs1_q,
    output logic [`XLEN-1:0] rs2_q
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,  // captured, decode and ALU settling
        S_DONE   // ack high, waiting for req to drop
    } state_e;

    state_e state;
    logic   capture;

    assign capture = (state == S_IDLE) && req && !ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            ack     <= 1'b0;
            result  <= '0;
            illegal <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (capture) begin
                        state <= S_BUSY;
                    end
                end
                S_BUSY: begin
                    result  <= alu_res;
                    illegal <= dec_illegal;
                    ack     <= 1'b1;
                    state   <= S_DONE;
                end
                S_DONE: begin
                    if (!req) begin  // phase 3 seen
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (capture) begin
            instr_q <= instr;
            rs1_q   <= rs1_val;
            rs2_q   <= rs2_val;
        end
    end

endmodule

//--- hw/rv32_exec_top.sv
// top level of the execute unit: handshake, decoder and ALU behind a req/ack port
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module rv32_exec_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] rs2_val,
    output logic             ack,
    output logic [`XLEN-1:0] result,
    output logic             illegal
);

    logic [`XLEN-1:0] instr_q;
    logic [`XLEN-1:0] rs1_q;
    logic [`XLEN-1:0] rs2_q;
    logic             dec_illegal;

    alu_if alu_bus ();

    exec_handshake u_handshake (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .instr       (instr),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .alu_res     (alu_bus.alu_res),
        .dec_illegal (dec_illegal),
        .ack         (ack),
        .result      (result),
        .illegal     (illegal),
        .instr_q     (instr_q),
        .rs1_q       (rs1_q),
        .rs2_q       (rs2_q)
    );

    exec_decoder u_decoder (
        .instr   (instr_q),
        .rs1_val (rs1_q),
        .rs2_val (rs2_q),
        .bus     (alu_bus.dec),
        .illegal (dec_illegal)
    );

    alu u_alu (
        .bus (alu_bus.alu)
    );

endmodule

//--- testbench/tb_rv32_exec.sv
// simulation top for rv32_exec_top that checks random RV32IM words against a local model
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module tb_rv32_exec import rv32_exec_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int ACK_LIMIT  = 16;
    localparam int N_HS    = 8;
    localparam int N_BASE  = 200;
    localparam int N_SHIFT = 48;
    localparam int N_MUL   = 144;
    localparam int N_DIV   = 180;
    localparam int N_MISC  = 60;
    localparam int N_TOTAL = N_HS + N_BASE + N_SHIFT + N_MUL + N_DIV + N_MISC;
    localparam logic [31:0] EXTREMES [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                             32'h7fff_ffff};

    logic             clk;
    logic             rst_n;
    logic             req;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic             ack;
    logic [`XLEN-1:0] result;
    logic             illegal;
    int               test_checks;
    int               test_errors;
    int               total_pass;
    int               total_fail;

    rv32_exec_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .instr   (instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .ack     (ack),
        .result  (result),
        .illegal (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget of 10 cycles per transaction plus a margin
    initial begin
        #(N_TOTAL * 10 * CLK_PERIOD + 20000);
        $display("watchdog expired, the tests did not complete in time");
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] rand32();
        return $urandom;
    endfunction

    function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [2:0] f3);
        logic [31:0] r;
        r = rand32();
        return {f7, r[24:20], r[19:15], f3, r[11:7], `OPC_OP};
    endfunction

    function automatic logic [31:0] make_i(input logic [11:0] imm, input logic [2:0] f3);
        logic [31:0] r;
        r = rand32();
        return {imm, r[19:15], f3, r[11:7], `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] base_result(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `F3_ADD:  return alt ? a - b : a + b;
            `F3_SLL:  return a << b[4:0];
            `F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:  return a ^ b;
            `F3_SRL: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            `F3_OR:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // min / -1 wraps back to min in 64-bit arithmetic
    function automatic logic [31:0] m_ext_result(input logic [2:0] f3, input logic [31:0] a,
                                                 input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      ua;
        longint      ub;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'({32'b0, a});
        ub = longint'({32'b0, b});
        if (f3[2] && b == '0) return f3[1] ? a : 32'hffff_ffff;
        case (f3)
            `F3_ADD,
            `F3_SLL:  p = sa * sb;
            `F3_SLT:  p = sa * ub;
            `F3_SLTU: p = ua * ub;
            `F3_XOR:  p = sa / sb;
            `F3_SRL:  p = ua / ub;
            `F3_OR:   p = sa % sb;
            default:  p = ua % ub;
        endcase
        return (f3 == `F3_ADD || f3[2]) ? p[31:0] : p[63:32];
    endfunction

    function automatic void ref_model(input logic [31:0] w, input logic [31:0] a,
                                      input logic [31:0] b, output logic [31:0] res,
                                      output logic ill);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm;
        f3  = w[14:12];
        f7  = w[31:25];
        imm = {{20{w[31]}}, w[31:20]};
        res = '0;
        ill = 1'b0;
        case (w[6:0])
            `OPC_OP: begin
                if (f7 == `F7_BASE) res = base_result(f3, 1'b0, a, b);
                else if (f7 == `F7_MULDIV) res = m_ext_result(f3, a, b);
                else if (f7 == `F7_ALT && (f3 == `F3_ADD || f3 == `F3_SRL)) begin
                    res = base_result(f3, 1'b1, a, b);
                end else ill = 1'b1;
            end
            `OPC_OP_IMM: begin
                if (f3 == `F3_SLL && f7 != `F7_BASE) ill = 1'b1;
                else if (f3 == `F3_SRL && f7 != `F7_BASE && f7 != `F7_ALT) ill = 1'b1;
                else res = base_result(f3, f3 == `F3_SRL && f7 == `F7_ALT, a, imm);
            end
            `OPC_LUI: res = {w[31:12], 12'b0};
            default:  ill = 1'b1;
        endcase
        if (ill) res = '0;
    endfunction

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        test_checks++;
        if (act !== exp) begin
            test_errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        test_checks++;
        if (act !== exp) begin
            test_errors++;
            $display("** Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic drive_request(input logic [31:0] w, input logic [31:0] a,
                                 input logic [31:0] b);
        @(posedge clk);
        #2;
        instr   = w;
        rs1_val = a;
        rs2_val = b;
        req     = 1'b1;
    endtask

    task automatic do_transaction(input logic [31:0] w, input logic [31:0] a,
                                  input logic [31:0] b, output logic [`XLEN-1:0] res,
                                  output logic ill);
        int n;
        drive_request(w, a, b);
        n = 0;
        while (!ack && n < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ack) begin
            test_checks++;
            test_errors++;
            $display("timeout, DUT gave no ack within %0d cycles for %h", ACK_LIMIT, w);
        end
        res = result;
        ill = illegal;
        req = 1'b0;
        n = 0;
        while (ack && n < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (ack) begin
            test_checks++;
            test_errors++;
            $display("DUT kept ack high after req was dropped for %h", w);
        end
    endtask

    task automatic issue_and_compare(input string tname, input logic [31:0] w,
                                     input logic [31:0] a, input logic [31:0] b);
        logic [`XLEN-1:0] res;
        logic             ill;
        logic [`XLEN-1:0] exp_res;
        logic             exp_ill;
        do_transaction(w, a, b, res, ill);
        ref_model(w, a, b, exp_res, exp_ill);
        check_word($sformatf("%s %h result", tname, w), exp_res, res);
        check_flag($sformatf("%s %h illegal", tname, w), exp_ill, ill);
    endtask

    task automatic report_test(input string tname);
        $display("%s: %0d checks, %0d errors", tname, test_checks, test_errors);
        total_pass += test_checks - test_errors;
        total_fail += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // fixed-edge checks of the four-phase sequence right after reset
    task automatic handshake_seq();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_res;
        logic        exp_ill;
        check_flag("reset ack", 1'b0, ack);
        check_flag("reset illegal", 1'b0, illegal);
        check_word("reset result", '0, result);
        for (int k = 0; k < N_HS; k++) begin
            w = make_r(`F7_BASE, k[2:0]);
            a = rand32();
            b = rand32();
            ref_model(w, a, b, exp_res, exp_ill);
            drive_request(w, a, b);
            @(posedge clk);
            #2;
            check_flag("handshake ack after 1 edge", 1'b0, ack);
            @(posedge clk);
            #2;
            check_flag("handshake ack after 2 edges", 1'b1, ack);
            check_word("handshake result", exp_res, result);
            for (int h = 0; h < k % 4; h++) begin
                @(posedge clk);
                #2;
                check_flag("handshake ack held with req", 1'b1, ack);
            end
            req     = 1'b0;
            instr   = rand32();  // idle bus noise
            rs1_val = rand32();
            @(posedge clk);
            #2;
            check_flag("handshake ack after req drop", 1'b0, ack);
            repeat (2) @(posedge clk);
            #2;
            check_word("handshake result held", exp_res, result);
        end
    endtask

    task automatic base_op_sweep();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] w;
        for (int k = 0; k < N_BASE; k++) begin
            r  = rand32();
            f3 = r[2:0];
            f7 = (r[4] && (f3 == `F3_SRL || (r[3] && f3 == `F3_ADD))) ? `F7_ALT : `F7_BASE;
            if (r[3]) w = make_r(f7, f3);
            else if (f3 == `F3_SLL || f3 == `F3_SRL) w = make_i({f7, r[20:16]}, f3);
            else w = make_i(r[31:20], f3);
            issue_and_compare("base_ops", w, rand32(), rand32());
        end
    endtask

    task automatic shift_sweep();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        for (int k = 0; k < N_SHIFT / 6; k++) begin
            a = rand32();
            if (k[0]) a[31] = 1'b1;  // negative operand
            b  = rand32() | 32'h0000_0020;
            sh = b[4:0];
            issue_and_compare("shifts", make_r(`F7_BASE, `F3_SLL), a, b);
            issue_and_compare("shifts", make_r(`F7_BASE, `F3_SRL), a, b);
            issue_and_compare("shifts", make_r(`F7_ALT, `F3_SRL), a, b);
            issue_and_compare("shifts", make_i({`F7_BASE, sh}, `F3_SLL), a, b);
            issue_and_compare("shifts", make_i({`F7_BASE, sh}, `F3_SRL), a, b);
            issue_and_compare("shifts", make_i({`F7_ALT, sh}, `F3_SRL), a, b);
        end
    endtask

    // hi picks div/rem instead of the multiplies
    task automatic m_ext_sweep(input string tname, input logic hi, input int n_ext);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < n_ext; i++) begin
            for (int j = 0; j < n_ext; j++) begin
                for (int f = 0; f < 4; f++) begin
                    issue_and_compare(tname, make_r(`F7_MULDIV, {hi, f[1:0]}),
                                      EXTREMES[i], EXTREMES[j]);
                end
            end
        end
        for (int k = 0; k < 20; k++) begin
            a = rand32();
            b = (hi && k % 5 == 0) ? 32'h0 : rand32();
            for (int f = 0; f < 4; f++) begin
                issue_and_compare(tname, make_r(`F7_MULDIV, {hi, f[1:0]}), a, b);
            end
        end
    endtask

    task automatic lui_and_illegal();
        logic [31:0] r;
        for (int k = 0; k < 20; k++) begin
            r = rand32();
            issue_and_compare("lui_illegal", {r[31:7], `OPC_LUI}, rand32(), rand32());
        end
        for (int k = 0; k < 20; k++) begin
            r = rand32();
            while (r[6:0] == `OPC_OP || r[6:0] == `OPC_OP_IMM || r[6:0] == `OPC_LUI) begin
                r = rand32();
            end
            issue_and_compare("lui_illegal", r, rand32(), rand32());
        end
        for (int k = 0; k < 10; k++) begin
            r = rand32();
            issue_and_compare("lui_illegal", make_r(r[31:25] | 7'h40, r[2:0]), rand32(),
                              rand32());
        end
        for (int k = 0; k < 10; k++) begin
            r = rand32();  // bit 31 set in a shift immediate is never legal
            issue_and_compare("lui_illegal",
                              make_i({r[31:25] | 7'h40, r[4:0]}, k[0] ? `F3_SLL : `F3_SRL),
                              rand32(), rand32());
        end
    endtask

    initial begin
        void'($urandom(32'h9543_5c6a));
        rst_n       = 1'b0;
        req         = 1'b0;
        instr       = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        test_checks = 0;
        test_errors = 0;
        total_pass  = 0;
        total_fail  = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        handshake_seq();
        report_test("handshake");
        base_op_sweep();
        report_test("base_ops");
        shift_sweep();
        report_test("shifts");
        m_ext_sweep("multiplies", 1'b0, 4);
        report_test("multiplies");
        m_ext_sweep("divides", 1'b1, 5);
        report_test("divides");
        lui_and_illegal();
        report_test("lui_illegal");
        $display("checks passed %0d, failed %0d", total_pass, total_fail);
        if (total_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- rv32_exec.f
+incdir+include
hw/rv32_exec_pkg.sv
hw/alu_if.sv
hw/alu.sv
hw/exec_decoder.sv
hw/exec_handshake.sv
hw/rv32_exec_top.sv
testbench/tb_rv32_exec.sv

//--- run_sim.sh
#!/bin/sh
# builds the RV32IM execute unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_rv32_exec -f rv32_exec.f -o sim_rv32_exec

out=$(./obj_dir/sim_rv32_exec)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
